/* Makefile */
# Verilator build and simulation of the core testbench

TOP := rv_core_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "Finished with errors" sim.log; then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q "Finished with no errors" sim.log; then \
		echo "Simulation ended without a result"; exit 1; \
	fi

lint:
	verilator --lint-only -Wall --timing --assert -f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

/* common/rv_core_macros.svh */
// Core-wide sizes and the instruction held in the instruction register at reset
// Included by the core package, every RTL module and the testbench
`ifndef RV_CORE_MACROS_SVH
`define RV_CORE_MACROS_SVH

// Data and address width
`define RV_XLEN 32

// Architectural registers, x0 included
`define RV_NUM_REGS 32

// ADDI x0, x0, 0
`define RV_NOP_INSTR 32'h0000_0013

`endif

/* common/rv_core_pkg.sv */
// Datapath selects, flow states and memory port structs of the core
// Used by the core, the decoder and the testbench memory models
`include "rv_core_macros.svh"

package rv_core_pkg;

   // ==========================================================
   // Mux selects
   // ==========================================================

   // ALU port A
   typedef enum logic {
      PORTA_RS1,
      PORTA_PC_EXE
   } porta_sel_e;

   // ALU port B
   typedef enum logic [1:0] {
      PORTB_RS2,
      PORTB_IMM,
      PORTB_SHAMT
   } portb_sel_e;

   // Next fetch address
   typedef enum logic [1:0] {
      PC_PLUS4,
      PC_COND_BRANCH,
      PC_ALU_RES
   } pc_sel_e;

   // Register write-back source
   typedef enum logic [1:0] {
      WB_ALU,
      WB_PC_PLUS4,
      WB_LOAD
   } wb_sel_e;

   // Flow FSM
   typedef enum logic [1:0] {
      PS_RESET,
      PS_CONT,
      PS_BRANCH,
      PS_LOAD_WAIT
   } pstate_e;

   // Decoded control word, 16 bits
   typedef struct packed {
      porta_sel_e          porta_sel;
      portb_sel_e          portb_sel;
      pc_sel_e             pc_sel;
      wb_sel_e             wb_sel;
      rv_isa_pkg::alu_op_e alu_op;
      logic                reg_write;
      logic                mem_read;
      logic                mem_write;
      logic                byte_store;
      logic                illegal;
   } ctrl_t;

   // ==========================================================
   // Memory ports
   // ==========================================================

   typedef struct packed {
      logic [`RV_XLEN-1:0] addr;
   } code_req_t;

   typedef struct packed {
      logic [`RV_XLEN-1:0] rdata;
      logic                ack;
   } code_rsp_t;

   // Nonzero bytesel marks a write
   typedef struct packed {
      logic                req;
      logic [`RV_XLEN-1:0] addr;
      logic [`RV_XLEN-1:0] wdata;
      logic [3:0]          bytesel;
   } data_req_t;

   typedef struct packed {
      logic [`RV_XLEN-1:0] rdata;
      logic                ack;
   } data_rsp_t;

endpackage

/* common/rv_isa_pkg.sv */
// RV32I encodings shared by the decoder, the ALU and the core
// Import inside a module body, use scoped names in port lists
package rv_isa_pkg;

   // Major opcodes, instruction bits 6:0
   typedef enum logic [6:0] {
      OPC_LUI    = 7'b0110111,
      OPC_AUIPC  = 7'b0010111,
      OPC_JAL    = 7'b1101111,
      OPC_JALR   = 7'b1100111,
      OPC_BRANCH = 7'b1100011,
      OPC_LOAD   = 7'b0000011,
      OPC_STORE  = 7'b0100011,
      OPC_OP_IMM = 7'b0010011,
      OPC_OP     = 7'b0110011
   } opcode_e;

   // funct3 of OP and OP-IMM
   typedef enum logic [2:0] {
      F3_ADD_SUB = 3'b000, F3_SLL = 3'b001, F3_SLT = 3'b010, F3_SLTU    = 3'b011,
      F3_XOR     = 3'b100, F3_OR  = 3'b110, F3_AND = 3'b111, F3_SRL_SRA = 3'b101
   } op_f3_e;

   // funct3 of conditional branches
   typedef enum logic [2:0] {
      F3_BEQ = 3'b000, F3_BNE  = 3'b001, F3_BLT  = 3'b100,
      F3_BGE = 3'b101, F3_BLTU = 3'b110, F3_BGEU = 3'b111
   } br_f3_e;

   // funct3 of loads and stores, only byte and word here
   typedef enum logic [2:0] {
      F3_B = 3'b000,
      F3_W = 3'b010
   } mem_f3_e;

   // ALU operations
   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL,
      ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B, ALU_EQ, ALU_NE
   } alu_op_e;

   // Raw register and funct3 fields, 18 bits
   typedef struct packed {
      logic [4:0] rs1;
      logic [4:0] rs2;
      logic [4:0] rd;
      logic [2:0] funct3;
   } dec_fields_t;

endpackage

/* core/rv_core.sv */
// Two-stage RV32I core, fetch then execute, with separate code and data ports
// Code port returns a word the cycle after the address, ack low stalls;
// data port holds its request until ack, and any stall freezes the core
`include "rv_core_macros.svh"

module rv_core (
   input  logic                   clk,
   input  logic                   rst_n,
   output rv_core_pkg::code_req_t code_req,
   input  rv_core_pkg::code_rsp_t code_rsp,
   output rv_core_pkg::data_req_t data_req,
   input  rv_core_pkg::data_rsp_t data_rsp
);
   import rv_isa_pkg::*;
   import rv_core_pkg::*;

   // Fetch and execute state
   logic [`RV_XLEN-1:0] instr_r;
   logic [`RV_XLEN-1:0] pc_fetch_r;
   logic [`RV_XLEN-1:0] pc_exe_r;
   logic                exe_valid_r;
   pstate_e             pstate_r;
   pstate_e             pstate_next;

   // Decode and datapath
   ctrl_t               ctrl;
   dec_fields_t         fields;
   logic [`RV_XLEN-1:0] imm;
   logic [`RV_XLEN-1:0] rf_porta;
   logic [`RV_XLEN-1:0] rf_portb;
   logic [`RV_XLEN-1:0] alu_porta;
   logic [`RV_XLEN-1:0] alu_portb;
   logic [`RV_XLEN-1:0] alu_res;
   logic [`RV_XLEN-1:0] rd_data;
   logic                alu_cond;
   logic                write_rd;

   // Flow control
   logic [`RV_XLEN-1:0] pc_next;
   logic [`RV_XLEN-1:0] branch_target;
   logic                branch_taken;
   logic                cond_taken;
   logic                exe_mem;
   logic                exe_stall;
   logic                fetch_ok;
   logic                hold_pc;

   // ==========================================================
   // Instruction register
   // ==========================================================
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         instr_r     <= `RV_NOP_INSTR;
         pc_exe_r    <= '0;
         exe_valid_r <= 1'b0;
      end else if (!exe_stall) begin
         // Bubble when nothing was accepted from fetch
         exe_valid_r <= fetch_ok;
         if (fetch_ok) begin
            instr_r  <= code_rsp.rdata;
            pc_exe_r <= pc_fetch_r;
         end
      end
   end

   rv_decoder u_decoder (
      .instr  (instr_r),
      .ctrl   (ctrl),
      .fields (fields),
      .imm    (imm)
   );

   // ==========================================================
   // Operands, ALU and write-back
   // ==========================================================
   rv_regfile u_regfile (
      .clk       (clk),
      .rst_n     (rst_n),
      .sel_porta (fields.rs1),
      .sel_portb (fields.rs2),
      .sel_rd    (fields.rd),
      .rd        (rd_data),
      .write_rd  (write_rd),
      .porta     (rf_porta),
      .portb     (rf_portb)
   );

   assign alu_porta = (ctrl.porta_sel == PORTA_PC_EXE) ? pc_exe_r : rf_porta;

   always_comb begin
      case (ctrl.portb_sel)
         PORTB_IMM:   alu_portb = imm;
         PORTB_SHAMT: alu_portb = {{(`RV_XLEN-5){1'b0}}, fields.rs2};
         default:     alu_portb = rf_portb;
      endcase
   end

   rv_alu u_alu (
      .alu_op   (ctrl.alu_op),
      .porta    (alu_porta),
      .portb    (alu_portb),
      .alu_res  (alu_res),
      .alu_cond (alu_cond)
   );

   always_comb begin
      case (ctrl.wb_sel)
         WB_PC_PLUS4: rd_data = pc_exe_r + 4;
         WB_LOAD:     rd_data = data_rsp.rdata;
         default:     rd_data = alu_res;
      endcase
   end

   // A load writes rd in its ack cycle
   assign write_rd = exe_valid_r && ctrl.reg_write && !exe_stall;

   // ==========================================================
   // Data port
   // ==========================================================
   assign exe_mem   = exe_valid_r && (ctrl.mem_read || ctrl.mem_write);
   assign exe_stall = exe_mem && !data_rsp.ack;

   always_comb begin
      data_req.req     = exe_mem;
      data_req.addr    = alu_res;
      // SB replicates the byte, bytesel picks the lane
      data_req.wdata   = ctrl.byte_store ? {4{rf_portb[7:0]}} : rf_portb;
      data_req.bytesel = 4'b0000;
      if (exe_valid_r && ctrl.mem_write) begin
         data_req.bytesel = ctrl.byte_store ? (4'b0001 << alu_res[1:0]) : 4'b1111;
      end
   end

   // ==========================================================
   // Branch resolution and next PC
   // ==========================================================

   // BGE and BGEU take the inverse of SLT and SLTU
   assign cond_taken = alu_cond ^ (fields.funct3 inside {F3_BGE, F3_BGEU});

   always_comb begin
      case (ctrl.pc_sel)
         PC_COND_BRANCH: begin
            branch_taken  = exe_valid_r && cond_taken;
            branch_target = pc_exe_r + imm;
         end
         PC_ALU_RES: begin
            // JALR clears bit 0
            branch_taken  = exe_valid_r;
            branch_target = {alu_res[`RV_XLEN-1:1], 1'b0};
         end
         default: begin
            branch_taken  = 1'b0;
            branch_target = pc_exe_r + imm;
         end
      endcase
   end

   always_comb begin
      if (branch_taken) begin
         pc_next = branch_target;
      end else if (hold_pc) begin
         pc_next = pc_fetch_r;
      end else begin
         pc_next = pc_fetch_r + 4;
      end
   end

   // Memory samples this address on every edge
   assign code_req.addr = pc_next;

   // ==========================================================
   // Flow FSM
   // ==========================================================
   always_comb begin
      fetch_ok    = 1'b0;
      hold_pc     = 1'b1;
      pstate_next = pstate_r;
      case (pstate_r)
         // Present address 0 once before taking any word
         PS_RESET: pstate_next = PS_CONT;
         PS_CONT, PS_LOAD_WAIT: begin
            if (exe_stall) begin
               pstate_next = PS_LOAD_WAIT;
            end else if (branch_taken) begin
               // Word in flight is from the wrong path
               hold_pc     = 1'b0;
               pstate_next = PS_BRANCH;
            end else begin
               fetch_ok    = code_rsp.ack;
               hold_pc     = !code_rsp.ack;
               pstate_next = PS_CONT;
            end
         end
         // Waiting for the target word, execute is empty
         PS_BRANCH: begin
            fetch_ok = code_rsp.ack;
            hold_pc  = !code_rsp.ack;
            if (code_rsp.ack) begin
               pstate_next = PS_CONT;
            end
         end
         default: pstate_next = PS_RESET;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pstate_r   <= PS_RESET;
         pc_fetch_r <= '0;
      end else begin
         pstate_r   <= pstate_next;
         pc_fetch_r <= pc_next;
      end
   end

endmodule

/* core/rv_decoder.sv */
// Combinational RV32I decoder for the execute stage
// Turns the instruction register into the control word, register fields
// and the sign-extended immediate of the instruction format
`include "rv_core_macros.svh"

module rv_decoder (
   input  logic [`RV_XLEN-1:0]     instr,
   output rv_core_pkg::ctrl_t      ctrl,
   output rv_isa_pkg::dec_fields_t fields,
   output logic [`RV_XLEN-1:0]     imm
);
   import rv_isa_pkg::*;
   import rv_core_pkg::*;

   // Control word of a no-op, no side effects
   localparam ctrl_t NOP_CTRL = '{
      porta_sel:  PORTA_RS1,
      portb_sel:  PORTB_RS2,
      pc_sel:     PC_PLUS4,
      wb_sel:     WB_ALU,
      alu_op:     ALU_ADD,
      reg_write:  1'b0,
      mem_read:   1'b0,
      mem_write:  1'b0,
      byte_store: 1'b0,
      illegal:    1'b0
   };

   opcode_e             opcode;
   op_f3_e              op_f3;
   logic                is_op;
   logic                f7_base;
   logic                f7_alt;
   logic                illegal;
   logic [`RV_XLEN-1:0] imm_i;
   logic [`RV_XLEN-1:0] imm_s;
   logic [`RV_XLEN-1:0] imm_b;
   logic [`RV_XLEN-1:0] imm_u;
   logic [`RV_XLEN-1:0] imm_j;

   assign opcode = opcode_e'(instr[6:0]);
   assign op_f3  = op_f3_e'(instr[14:12]);
   assign is_op  = (opcode == OPC_OP);

   // funct7 of zero, or bit 30 alone for SUB and SRA
   assign f7_base = (instr[31:25] == 7'b0000000);
   assign f7_alt  = (instr[31:25] == 7'b0100000);

   assign fields = '{
      rs1:    instr[19:15],
      rs2:    instr[24:20],
      rd:     instr[11:7],
      funct3: instr[14:12]
   };

   // ==========================================================
   // Immediates of each format
   // ==========================================================
   assign imm_i = {{20{instr[31]}}, instr[31:20]};
   assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
   assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
   assign imm_u = {instr[31:12], 12'b0};
   assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

   // ==========================================================
   // Opcode and funct match
   // ==========================================================
   always_comb begin
      ctrl    = NOP_CTRL;
      imm     = imm_i;
      illegal = 1'b0;
      case (opcode)
         OPC_LUI: begin
            ctrl.portb_sel = PORTB_IMM;
            ctrl.alu_op    = ALU_PASS_B;
            ctrl.reg_write = 1'b1;
            imm            = imm_u;
         end
         OPC_AUIPC: begin
            ctrl.porta_sel = PORTA_PC_EXE;
            ctrl.portb_sel = PORTB_IMM;
            ctrl.reg_write = 1'b1;
            imm            = imm_u;
         end
         // Jumps compute the target in the ALU and link PC+4
         OPC_JAL: begin
            ctrl.porta_sel = PORTA_PC_EXE;
            ctrl.portb_sel = PORTB_IMM;
            ctrl.pc_sel    = PC_ALU_RES;
            ctrl.wb_sel    = WB_PC_PLUS4;
            ctrl.reg_write = 1'b1;
            imm            = imm_j;
         end
         OPC_JALR: begin
            ctrl.portb_sel = PORTB_IMM;
            ctrl.pc_sel    = PC_ALU_RES;
            ctrl.wb_sel    = WB_PC_PLUS4;
            ctrl.reg_write = 1'b1;
            illegal        = (instr[14:12] != 3'b000);
         end
         // ALU compares rs1 and rs2, target adder lives in the core
         OPC_BRANCH: begin
            ctrl.pc_sel = PC_COND_BRANCH;
            imm         = imm_b;
            case (br_f3_e'(instr[14:12]))
               F3_BEQ:           ctrl.alu_op = ALU_EQ;
               F3_BNE:           ctrl.alu_op = ALU_NE;
               F3_BLT, F3_BGE:   ctrl.alu_op = ALU_SLT;
               F3_BLTU, F3_BGEU: ctrl.alu_op = ALU_SLTU;
               default:          illegal     = 1'b1;
            endcase
         end
         // LW only
         OPC_LOAD: begin
            ctrl.portb_sel = PORTB_IMM;
            ctrl.mem_read  = 1'b1;
            ctrl.wb_sel    = WB_LOAD;
            ctrl.reg_write = 1'b1;
            illegal        = (instr[14:12] != F3_W);
         end
         // SW and SB
         OPC_STORE: begin
            ctrl.portb_sel  = PORTB_IMM;
            ctrl.mem_write  = 1'b1;
            ctrl.byte_store = (instr[14:12] == F3_B);
            imm             = imm_s;
            illegal         = (instr[14:12] != F3_W) && (instr[14:12] != F3_B);
         end
         OPC_OP_IMM, OPC_OP: begin
            ctrl.reg_write = 1'b1;
            ctrl.portb_sel = is_op ? PORTB_RS2 : PORTB_IMM;
            case (op_f3)
               F3_ADD_SUB: ctrl.alu_op = (is_op && f7_alt) ? ALU_SUB : ALU_ADD;
               F3_SLL:     ctrl.alu_op = ALU_SLL;
               F3_SLT:     ctrl.alu_op = ALU_SLT;
               F3_SLTU:    ctrl.alu_op = ALU_SLTU;
               F3_XOR:     ctrl.alu_op = ALU_XOR;
               F3_SRL_SRA: ctrl.alu_op = f7_alt ? ALU_SRA : ALU_SRL;
               F3_OR:      ctrl.alu_op = ALU_OR;
               F3_AND:     ctrl.alu_op = ALU_AND;
               default:    ctrl.alu_op = ALU_ADD;
            endcase
            // Immediate shifts take shamt from the rs2 field
            if (!is_op && (op_f3 == F3_SLL || op_f3 == F3_SRL_SRA)) begin
               ctrl.portb_sel = PORTB_SHAMT;
            end
            // funct7 matters for OP and for every shift
            if (is_op || op_f3 == F3_SLL || op_f3 == F3_SRL_SRA) begin
               illegal = !(f7_base ||
                           (f7_alt && (op_f3 == F3_SRL_SRA ||
                                       (is_op && op_f3 == F3_ADD_SUB))));
            end
         end
         default: illegal = 1'b1;
      endcase

      // Unknown encodings retire as no-ops
      if (illegal) begin
         ctrl         = NOP_CTRL;
         ctrl.illegal = 1'b1;
      end
   end

endmodule

/* rtl/rv_alu.sv */
// Combinational ALU of the execute stage
// alu_cond carries the compare outcome that conditional branches use
`include "rv_core_macros.svh"

module rv_alu (
   input  rv_isa_pkg::alu_op_e alu_op,
   input  logic [`RV_XLEN-1:0] porta,
   input  logic [`RV_XLEN-1:0] portb,
   output logic [`RV_XLEN-1:0] alu_res,
   output logic                alu_cond
);
   import rv_isa_pkg::*;

   logic       is_eq;
   logic       lt_s;
   logic       lt_u;
   logic [4:0] shamt;

   // Compares shared by SLT and the branches
   assign is_eq = (porta == portb);
   assign lt_s  = ($signed(porta) < $signed(portb));
   assign lt_u  = (porta < portb);

   // Only the low five bits shift
   assign shamt = portb[4:0];

   always_comb begin
      alu_res = '0;
      case (alu_op)
         ALU_ADD:    alu_res = porta + portb;
         ALU_SUB:    alu_res = porta - portb;
         ALU_SLL:    alu_res = porta << shamt;
         ALU_SLT:    alu_res = {{(`RV_XLEN-1){1'b0}}, lt_s};
         ALU_SLTU:   alu_res = {{(`RV_XLEN-1){1'b0}}, lt_u};
         ALU_XOR:    alu_res = porta ^ portb;
         ALU_SRL:    alu_res = porta >> shamt;
         ALU_SRA:    alu_res = $signed(porta) >>> shamt;
         ALU_OR:     alu_res = porta | portb;
         ALU_AND:    alu_res = porta & portb;
         // LUI passes the immediate through
         ALU_PASS_B: alu_res = portb;
         ALU_EQ:     alu_res = {{(`RV_XLEN-1){1'b0}}, is_eq};
         ALU_NE:     alu_res = {{(`RV_XLEN-1){1'b0}}, !is_eq};
         default:    alu_res = '0;
      endcase
   end

   // BGE and BGEU invert the SLT and SLTU outcome in the core
   always_comb begin
      case (alu_op)
         ALU_EQ:   alu_cond = is_eq;
         ALU_NE:   alu_cond = !is_eq;
         ALU_SLT:  alu_cond = lt_s;
         ALU_SLTU: alu_cond = lt_u;
         default:  alu_cond = 1'b0;
      endcase
   end

endmodule

/* rtl/rv_regfile.sv */
// Integer register file, two combinational read ports and one write port
// x0 reads as zero and ignores writes
`include "rv_core_macros.svh"

module rv_regfile (
   input  logic                clk,
   input  logic                rst_n,
   input  logic [4:0]          sel_porta,
   input  logic [4:0]          sel_portb,
   input  logic [4:0]          sel_rd,
   input  logic [`RV_XLEN-1:0] rd,
   input  logic                write_rd,
   output logic [`RV_XLEN-1:0] porta,
   output logic [`RV_XLEN-1:0] portb
);

   // x1 to x31, x0 has no storage
   logic [`RV_XLEN-1:0] regs [1:`RV_NUM_REGS-1];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 1; i < `RV_NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (write_rd && (sel_rd != 5'd0)) begin
         regs[sel_rd] <= rd;
      end
   end

   // Reads bypass nothing, a write shows up the cycle after
   assign porta = (sel_porta == 5'd0) ? '0 : regs[sel_porta];
   assign portb = (sel_portb == 5'd0) ? '0 : regs[sel_portb];

endmodule

/* verification/rv_core_assert.sv */
// Port protocol checks for the core, bound into every rv_core instance
// Reports only through failing concurrent assertions
`include "rv_core_macros.svh"

module rv_core_assert (
   input logic                   clk,
   input logic                   rst_n,
   input rv_core_pkg::code_req_t code_req,
   input rv_core_pkg::code_rsp_t code_rsp,
   input rv_core_pkg::data_req_t data_req,
   input rv_core_pkg::data_rsp_t data_rsp,
   input logic [`RV_XLEN-1:0]    pc_fetch,
   input logic                   branch_taken
);
   import rv_core_pkg::*;

   // No data request while reset is held
   a_no_req_in_reset: assert property (@(posedge clk) !rst_n |-> !data_req.req)
      else $error("data request raised during reset");

   // Request holds all of its fields until acknowledged
   a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
      data_req.req && !data_rsp.ack |=> $stable(data_req))
      else $error("data request changed before ack");

   // No lanes, all four lanes, or exactly one lane
   a_bytesel_legal: assert property (@(posedge clk) disable iff (!rst_n)
      data_req.bytesel inside {4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b1111})
      else $error("illegal bytesel pattern");

   // Stalled fetch keeps presenting the same word address
   a_code_addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
      !code_rsp.ack && !branch_taken |-> code_req.addr == pc_fetch)
      else $error("code address moved while code ack was low");

endmodule

bind rv_core rv_core_assert u_core_assert (
   .clk          (clk),
   .rst_n        (rst_n),
   .code_req     (code_req),
   .code_rsp     (code_rsp),
   .data_req     (data_req),
   .data_rsp     (data_rsp),
   .pc_fetch     (pc_fetch_r),
   .branch_taken (branch_taken)
);

/* verification/rv_core_stimulus.txt */
// Counts: program words, data words, stores; then program, data,
// then stores as address, data, bytesel
00000027 00000002 0000000c
00500093 ffd00113 002081b3 40208233 04302023 04402223 001122b3 40115313
04502423 04602623 123453b7 0ff3c413 04802823 00208463 04102a23 00114463
04202c23 00117463 04202c23 00109463 04402c23 008004ef 04202e23 04902e23
07000513 000505e7 06202023 06202023 06b02023 00002603 00160693 06d02223
00402703 06e004a3 00115463 061005a3 0020e463 06102623 0000006f
// Preloaded data words 0 and 1
11223344 cafebabe
// Arithmetic, shifts and LUI results
00000040 00000002 f
00000044 00000008 f
00000048 00000001 f
0000004c fffffffe f
00000050 123450ff f
// Branch markers, JAL and JALR links
00000054 00000005 f
00000058 00000008 f
0000005c 00000058 f
00000060 00000068 f
// Load use and byte stores
00000064 11223345 f
00000069 bebebebe 2
0000006b 05050505 8

/* verification/rv_core_tb.sv */
// Testbench for the two-stage RV32I core
// Models code and data memory with random stalls, loads program, data and
// expected stores from the stimulus file and checks every store in order
`include "rv_core_macros.svh"

module rv_core_tb;
   import rv_core_pkg::*;

   localparam int RESET_CYCLES    = 10;
   localparam int MEM_WORDS       = 64;
   localparam int STIM_WORDS      = 256;
   localparam int CYCLES_PER_WORD = 40;
   // One stall in four per port, worst case taken as four times longer
   localparam int STALL_FACTOR    = 4;
   localparam int TAIL_CYCLES     = 50;

   logic      clk;
   logic      rst_n;
   code_req_t code_req;
   code_rsp_t code_rsp;
   data_req_t data_req;
   data_rsp_t data_rsp;

   logic [31:0] stim [0:STIM_WORDS-1];
   logic [31:0] code_mem [0:MEM_WORDS-1];
   logic [31:0] data_mem [0:MEM_WORDS-1];
   logic [31:0] exp_addr [0:MEM_WORDS-1];
   logic [31:0] exp_data [0:MEM_WORDS-1];
   logic [3:0]  exp_bytesel [0:MEM_WORDS-1];
   logic [31:0] code_addr_q;
   int          n_prog;
   int          n_data;
   int          n_stores;
   int          store_idx;
   int          value_errors;
   int          seq_errors;
   logic        loaded;

   tb_clock u_clock (.clk(clk));

   rv_core uut (
      .clk      (clk),
      .rst_n    (rst_n),
      .code_req (code_req),
      .code_rsp (code_rsp),
      .data_req (data_req),
      .data_rsp (data_rsp)
   );

   // Unused words decode as an illegal opcode
   function automatic logic [31:0] code_fill(input logic [31:0] addr);
      return {addr[24:0] ^ {18'h2d2d2, addr[31:25]}, 7'h7f};
   endfunction

   function automatic logic [31:0] data_fill(input logic [31:0] addr);
      return addr ^ 32'hd00d_0000;
   endfunction

   task automatic report_counts();
      $display("value errors: %0d, sequence errors: %0d, stores seen: %0d of %0d",
               value_errors, seq_errors, store_idx, n_stores);
   endtask

   // Compare one completed store with the next expected entry
   task automatic check_store(input data_req_t req);
      if (store_idx >= n_stores) begin
         $display("Unexpected store to address %h after the expected list ended",
                  req.addr);
         seq_errors++;
      end else begin
         assert (req.addr == exp_addr[store_idx])
            else begin
               $display("ERROR: data_req.addr got %h expected %h",
                        req.addr, exp_addr[store_idx]);
               value_errors++;
            end
         assert (req.wdata == exp_data[store_idx])
            else begin
               $display("ERROR: data_req.wdata got %h expected %h",
                        req.wdata, exp_data[store_idx]);
               value_errors++;
            end
         assert (req.bytesel == exp_bytesel[store_idx])
            else begin
               $display("ERROR: data_req.bytesel got %h expected %h",
                        req.bytesel, exp_bytesel[store_idx]);
               value_errors++;
            end
         store_idx++;
      end
   endtask

   task automatic write_data(input data_req_t req);
      for (int b = 0; b < 4; b++) begin
         if (req.bytesel[b]) begin
            data_mem[req.addr[7:2]][b*8 +: 8] = req.wdata[b*8 +: 8];
         end
      end
   endtask

   // ============================================================
   // Memory models
   // ============================================================

   // Code memory registers the address like a synchronous RAM
   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         code_addr_q <= '0;
      end else begin
         code_addr_q <= code_req.addr;
      end
   end

   // Both ports answer on the falling edge, fixed order keeps draws repeatable
   initial begin
      logic code_ack;
      void'($urandom(32'h334a));
      code_rsp = '0;
      data_rsp = '0;
      forever begin
         @(negedge clk);
         // Code stall drawn every cycle, reset or not
         code_ack = (($urandom % 4) != 0);
         if (!rst_n) begin
            code_rsp = '0;
            data_rsp = '0;
         end else begin
            code_rsp.rdata = code_mem[code_addr_q[7:2]];
            code_rsp.ack   = code_ack;
            data_rsp.ack   = 1'b0;
            if (data_req.req && (($urandom % 4) != 0)) begin
               data_rsp.ack   = 1'b1;
               data_rsp.rdata = data_mem[data_req.addr[7:2]];
               // Write completes at the coming edge
               if (data_req.bytesel != 4'b0000) begin
                  check_store(data_req);
                  write_data(data_req);
               end
            end
         end
      end
   end

   // ============================================================
   // Main sequence
   // ============================================================
   initial begin
      int base;
      rst_n        = 1'b0;
      loaded       = 1'b0;
      store_idx    = 0;
      value_errors = 0;
      seq_errors   = 0;

      // Counts first, then program, data and store triples
      $readmemh("verification/rv_core_stimulus.txt", stim);
      n_prog   = stim[0];
      n_data   = stim[1];
      n_stores = stim[2];
      for (int i = 0; i < MEM_WORDS; i++) begin
         code_mem[i] = code_fill(i * 4);
         data_mem[i] = data_fill(i * 4);
      end
      for (int i = 0; i < n_prog; i++) begin
         code_mem[i] = stim[3 + i];
      end
      for (int i = 0; i < n_data; i++) begin
         data_mem[i] = stim[3 + n_prog + i];
      end
      base = 3 + n_prog + n_data;
      for (int i = 0; i < n_stores; i++) begin
         exp_addr[i]    = stim[base + 3 * i];
         exp_data[i]    = stim[base + 3 * i + 1];
         exp_bytesel[i] = stim[base + 3 * i + 2][3:0];
      end
      loaded = 1'b1;

      repeat (RESET_CYCLES) @(negedge clk);
      rst_n = 1'b1;
      // Right after reset the core asks for address 0 and no data
      #1;
      assert (code_req.addr == 32'h0)
         else begin
            $display("ERROR: code_req.addr got %h expected %h", code_req.addr, 32'h0);
            value_errors++;
         end
      assert (!data_req.req)
         else begin
            $display("Data request raised directly after reset");
            seq_errors++;
         end

      wait (store_idx >= n_stores);
      // Room for any store that should never come
      repeat (TAIL_CYCLES) @(negedge clk);
      report_counts();
      if (value_errors == 0 && seq_errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

   // Watchdog scaled by program length and stall rate
   initial begin
      wait (loaded);
      repeat (RESET_CYCLES + n_prog * CYCLES_PER_WORD * STALL_FACTOR) @(posedge clk);
      $display("Timeout, %0d expected stores never completed", n_stores - store_idx);
      report_counts();
      $display("Finished with errors");
      $finish;
   end

endmodule

/* verification/tb_clock.sv */
// Free-running testbench clock, period of 10 time units
// Instantiated once by the testbench top
module tb_clock (
   output logic clk
);

   // Start low so the first rising edge lands at time 5
   initial begin
      clk = 1'b0;
   end

   always begin
      #5 clk = ~clk;
   end

endmodule

/* vlog.f */
+incdir+common
common/rv_isa_pkg.sv
common/rv_core_pkg.sv
rtl/rv_regfile.sv
rtl/rv_alu.sv
core/rv_decoder.sv
core/rv_core.sv
verification/tb_clock.sv
verification/rv_core_assert.sv
verification/rv_core_tb.sv
